//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 16;     // data word and instruction
	localparam int regAddrWidth = 4;   // sixteen registers
	localparam int imemAddrWidth = 8;  // 256 words
	localparam int dmemAddrWidth = 8;

	// opcodes
	localparam logic [3:0] opAdd = 4'b0000;
	localparam logic [3:0] opSub = 4'b0001;
	localparam logic [3:0] opXor = 4'b0010;
	localparam logic [3:0] opRed = 4'b0011;     // not implemented
	localparam logic [3:0] opSll = 4'b0100;
	localparam logic [3:0] opSra = 4'b0101;
	localparam logic [3:0] opRor = 4'b0110;
	localparam logic [3:0] opPaddsb = 4'b0111;  // not implemented
	localparam logic [3:0] opLw = 4'b1000;
	localparam logic [3:0] opSw = 4'b1001;
	localparam logic [3:0] opLlb = 4'b1010;
	localparam logic [3:0] opLhb = 4'b1011;
	localparam logic [3:0] opB = 4'b1100;
	localparam logic [3:0] opBr = 4'b1101;      // dropped
	localparam logic [3:0] opPcs = 4'b1110;
	localparam logic [3:0] opHlt = 4'b1111;

	// branch conditions
	localparam logic [2:0] condNeq = 3'b000;
	localparam logic [2:0] condEq = 3'b001;
	localparam logic [2:0] condGt = 3'b010;
	localparam logic [2:0] condLt = 3'b011;
	localparam logic [2:0] condGte = 3'b100;
	localparam logic [2:0] condLte = 3'b101;
	localparam logic [2:0] condOvfl = 3'b110;
	localparam logic [2:0] condUncond = 3'b111;

	typedef struct packed {
		logic [3:0] opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;  // also shift amount / offset
	} regFmtT;

	typedef struct packed {
		logic [3:0] opcode;
		logic [regAddrWidth-1:0] rd;
		logic [7:0] imm8;
	} byteFmtT;

	typedef struct packed {
		logic [3:0] opcode;
		logic [2:0] cond;
		logic [8:0] imm9;  // signed word offset
	} brFmtT;

	typedef union packed {
		regFmtT rFmt;
		byteFmtT bFmt;
		brFmtT brFmt;
	} instrT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic useImm;
		logic isPcs;
		logic isHalt;
		logic [2:0] flagEnable;  // z v n
		logic [3:0] aluOp;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [dataWidth-1:0] pcNext;
		instrT instr;
	} ifIdT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [regAddrWidth-1:0] rsId;
		logic [regAddrWidth-1:0] rtId;
		logic [regAddrWidth-1:0] rdId;
		logic [dataWidth-1:0] srcA;
		logic [dataWidth-1:0] srcB;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] pcNext;
	} idExT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [regAddrWidth-1:0] rdId;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] rdId;
		logic [dataWidth-1:0] data;
	} writeT;

	typedef struct packed {
		logic we;
		logic [imemAddrWidth-1:0] addr;  // word address
		logic [dataWidth-1:0] data;
	} loadT;

endpackage

`default_nettype wire

//--- logic/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

module fetchStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire loadT load,
	input wire logic stall,
	input wire logic branchTaken,
	input wire logic [dataWidth-1:0] branchTarget,
	input wire logic haltSeen,
	output ifIdT ifId,
	output logic [dataWidth-1:0] pc
);

	logic [dataWidth-1:0] imem [2**imemAddrWidth];
	logic [dataWidth-1:0] pcPlus2;
	logic [dataWidth-1:0] pcD;
	instrT fetched;
	logic fetchedHlt;
	logic frozen;  // halt passed on, fetch is done

	// loader writes while core sits in reset
	always_ff @(posedge clk) begin
		if (load.we)
			imem[load.addr] <= load.data;
	end

	assign fetched = imem[pc[imemAddrWidth:1]];  // byte pc to word index
	assign fetchedHlt = fetched.rFmt.opcode == opHlt;
	assign pcPlus2 = pc + dataWidth'(2);

	// branch wins, then hold, then increment
	always_comb begin
		if (branchTaken)
			pcD = branchTarget;
		else if (stall || haltSeen || frozen || fetchedHlt)
			pcD = pc;  // park on the HLT
		else
			pcD = pcPlus2;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			frozen <= 1'b0;
		end else begin
			pc <= pcD;
			if (haltSeen)
				frozen <= 1'b1;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk) begin
		if (!stall) begin
			ifId.pcNext <= pcPlus2;
			ifId.instr <= fetched;
		end
		if (!rstN)
			ifId.valid <= 1'b0;
		else if (branchTaken || haltSeen || frozen)
			ifId.valid <= 1'b0;  // squash, or no second HLT
		else if (!stall)
			ifId.valid <= 1'b1;
	end

	// once HLT is decoded no redirect may move fetch off it
	pcHoldOnHalt: assert property (@(posedge clk) disable iff (!rstN)
		(haltSeen || frozen) |=> $stable(pc));

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire ifIdT ifId,
	input wire flagsT flags,
	input wire ctrlT exCtrl,  // already zero for a bubble
	input wire logic [regAddrWidth-1:0] exRdId,
	input wire writeT wb,
	output idExT idEx,
	output logic stall,
	output logic branchTaken,
	output logic [dataWidth-1:0] branchTarget,
	output logic haltSeen
);

	logic [dataWidth-1:0] regs [2**regAddrWidth];
	instrT ins;
	logic [3:0] op;
	ctrlT ctrl;
	logic [regAddrWidth-1:0] rsId, rtId;
	logic usesRs, usesRt, writesRd;
	logic [dataWidth-1:0] imm;
	logic [dataWidth-1:0] rsVal, rtVal;
	logic condMet, loadUse, flagHazard;

	assign ins = ifId.instr;
	assign op = ins.rFmt.opcode;

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = op;  // opcode doubles as alu op
		usesRs = 1'b0;
		usesRt = 1'b0;
		writesRd = 1'b0;
		rsId = ins.rFmt.rs;
		rtId = ins.rFmt.rt;
		imm = '0;
		case (op)
			opAdd, opSub: begin
				writesRd = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
				ctrl.flagEnable = 3'b111;
			end
			opXor: begin
				writesRd = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
				ctrl.flagEnable = 3'b100;  // z only
			end
			opSll, opSra, opRor: begin
				writesRd = 1'b1;
				usesRs = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.flagEnable = 3'b100;
				imm = {{(dataWidth-4){1'b0}}, ins.rFmt.rt};  // shift amount
			end
			opLw, opSw: begin
				usesRs = 1'b1;  // base
				ctrl.useImm = 1'b1;
				imm = {{(dataWidth-4){ins.rFmt.rt[3]}}, ins.rFmt.rt};  // signed word offset
				writesRd = op == opLw;
				ctrl.memRead = op == opLw;
				ctrl.memToReg = op == opLw;
				ctrl.memWrite = op == opSw;
				usesRt = op == opSw;
				rtId = ins.rFmt.rd;  // store data sits in rd field
			end
			opLlb, opLhb: begin
				writesRd = 1'b1;
				usesRs = 1'b1;
				rsId = ins.bFmt.rd;  // old value kept in other half
				ctrl.useImm = 1'b1;
				imm = (op == opLlb) ? {8'h00, ins.bFmt.imm8} : {ins.bFmt.imm8, 8'h00};
			end
			opPcs: begin
				writesRd = 1'b1;
				ctrl.isPcs = 1'b1;
			end
			opHlt: ctrl.isHalt = 1'b1;
			opB, opBr, opRed, opPaddsb: begin
				// B resolves below, the others run as no-ops
			end
			default: ;
		endcase
		ctrl.regWrite = writesRd && (ins.rFmt.rd != '0);  // r0 stays zero
	end

	// register file, writeback visible same cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end else if (wb.valid && wb.rdId != '0)
			regs[wb.rdId] <= wb.data;
	end

	always_comb begin
		rsVal = regs[rsId];
		rtVal = regs[rtId];
		if (wb.valid && wb.rdId == rsId)
			rsVal = wb.data;  // bypass
		if (wb.valid && wb.rdId == rtId)
			rtVal = wb.data;
		if (rsId == '0)
			rsVal = '0;
		if (rtId == '0)
			rtVal = '0;
	end

	always_comb begin
		case (ins.brFmt.cond)
			condNeq: condMet = !flags.z;
			condEq: condMet = flags.z;
			condGt: condMet = !flags.z && !flags.n;
			condLt: condMet = flags.n;
			condGte: condMet = flags.z || !flags.n;
			condLte: condMet = flags.z || flags.n;
			condOvfl: condMet = flags.v;
			condUncond: condMet = 1'b1;
			default: condMet = 1'b0;
		endcase
	end

	// load in execute feeding this instruction
	assign loadUse = exCtrl.memRead && exCtrl.regWrite &&
		((usesRs && rsId == exRdId) || (usesRt && rtId == exRdId));
	assign flagHazard = (op == opB) && (exCtrl.flagEnable != '0);  // flags not yet committed
	assign stall = ifId.valid && (loadUse || flagHazard);

	assign branchTaken = ifId.valid && (op == opB) && condMet && !stall;
	assign branchTarget = ifId.pcNext + {{6{ins.brFmt.imm9[8]}}, ins.brFmt.imm9, 1'b0};
	assign haltSeen = ifId.valid && (op == opHlt);

	// decode/execute register
	always_ff @(posedge clk) begin
		idEx.ctrl <= ctrl;
		idEx.rsId <= rsId;
		idEx.rtId <= rtId;
		idEx.rdId <= ins.rFmt.rd;
		idEx.srcA <= rsVal;
		idEx.srcB <= rtVal;
		idEx.imm <= imm;
		idEx.pcNext <= ifId.pcNext;
		if (!rstN)
			idEx.valid <= 1'b0;
		else
			idEx.valid <= ifId.valid && !stall;  // bubble on stall
	end

	noWriteToR0: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> wb.rdId != '0);

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire idExT idEx,
	input wire writeT memFwd,
	input wire writeT wbFwd,
	output exMemT exMem,
	output flagsT flags,
	output ctrlT exCtrl,
	output logic [regAddrWidth-1:0] exRdId
);

	logic [dataWidth-1:0] aVal, rtVal, bVal;
	logic [dataWidth-1:0] sum, diff, satVal;
	logic [dataWidth-1:0] aluOut, result;
	logic [2*dataWidth-1:0] rorFull;
	logic addOvf, subOvf, ovf;
	flagsT newFlags;

	// youngest producer wins
	function automatic logic [dataWidth-1:0] pickSrc(
		input logic [regAddrWidth-1:0] id,
		input logic [dataWidth-1:0] regVal,
		input writeT mem,
		input writeT wbk
	);
		if (mem.valid && mem.rdId == id)
			return mem.data;
		if (wbk.valid && wbk.rdId == id)
			return wbk.data;
		return regVal;
	endfunction

	assign aVal = pickSrc(idEx.rsId, idEx.srcA, memFwd, wbFwd);
	assign rtVal = pickSrc(idEx.rtId, idEx.srcB, memFwd, wbFwd);
	assign bVal = idEx.ctrl.useImm ? idEx.imm : rtVal;

	always_comb begin
		sum = aVal + bVal;
		diff = aVal - bVal;
		addOvf = (aVal[dataWidth-1] == bVal[dataWidth-1]) &&
			(sum[dataWidth-1] != aVal[dataWidth-1]);
		subOvf = (aVal[dataWidth-1] != bVal[dataWidth-1]) &&
			(diff[dataWidth-1] != aVal[dataWidth-1]);
		satVal = {aVal[dataWidth-1], {(dataWidth-1){!aVal[dataWidth-1]}}};  // clamp toward a's sign
		rorFull = {aVal, aVal} >> bVal[3:0];
		ovf = 1'b0;
		case (idEx.ctrl.aluOp)
			opAdd: begin
				ovf = addOvf;
				aluOut = addOvf ? satVal : sum;
			end
			opSub: begin
				ovf = subOvf;
				aluOut = subOvf ? satVal : diff;
			end
			opXor: aluOut = aVal ^ bVal;
			opSll: aluOut = aVal << bVal[3:0];
			opSra: aluOut = $signed(aVal) >>> bVal[3:0];
			opRor: aluOut = rorFull[dataWidth-1:0];
			opLw, opSw: aluOut = aVal + (bVal << 1);  // byte address
			opLlb: aluOut = {aVal[dataWidth-1:8], bVal[7:0]};
			opLhb: aluOut = {bVal[dataWidth-1:8], aVal[7:0]};
			default: aluOut = '0;
		endcase
	end

	assign result = idEx.ctrl.isPcs ? idEx.pcNext : aluOut;

	assign newFlags.z = aluOut == '0;
	assign newFlags.v = ovf;
	assign newFlags.n = aluOut[dataWidth-1];

	// per flag enable, bubbles leave flags alone
	always_ff @(posedge clk) begin
		if (!rstN)
			flags <= '0;
		else if (idEx.valid)
			flags <= (flags & ~idEx.ctrl.flagEnable) | (newFlags & idEx.ctrl.flagEnable);
	end

	// execute/memory register
	always_ff @(posedge clk) begin
		exMem.ctrl <= idEx.ctrl;
		exMem.rdId <= idEx.rdId;
		exMem.aluResult <= result;
		exMem.storeData <= rtVal;  // forwarded store value
		if (!rstN)
			exMem.valid <= 1'b0;
		else
			exMem.valid <= idEx.valid;
	end

	// echo for hazard checks in decode
	assign exCtrl = idEx.valid ? idEx.ctrl : '0;
	assign exRdId = idEx.rdId;

endmodule

`default_nettype wire

//--- logic/resultStage.sv
`timescale 1ns/100ps
`default_nettype none

module resultStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire exMemT exMem,
	output writeT memFwd,
	output writeT wb,
	output logic hlt
);

	logic [dataWidth-1:0] dmem [2**dmemAddrWidth];
	logic [dmemAddrWidth-1:0] addr;
	logic [dataWidth-1:0] rdData;

	assign addr = exMem.aluResult[dmemAddrWidth:1];  // word index

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.ctrl.memWrite)
			dmem[addr] <= exMem.storeData;
	end

	assign rdData = exMem.ctrl.memRead ? dmem[addr] : '0;

	// loads not tapped here, load-use stall covers them
	assign memFwd.valid = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memToReg;
	assign memFwd.rdId = exMem.rdId;
	assign memFwd.data = exMem.aluResult;

	// memory/writeback register plus halt latch
	always_ff @(posedge clk) begin
		wb.rdId <= exMem.rdId;
		wb.data <= exMem.ctrl.memToReg ? rdData : exMem.aluResult;
		if (!rstN) begin
			wb.valid <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wb.valid <= exMem.valid && exMem.ctrl.regWrite;
			if (exMem.valid && exMem.ctrl.isHalt)
				hlt <= 1'b1;  // sticky until reset
		end
	end

	memAccessExclusive: assert property (@(posedge clk) disable iff (!rstN)
		exMem.valid |-> !(exMem.ctrl.memRead && exMem.ctrl.memWrite));

	// nothing younger than HLT ever reaches writeback
	quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
		hlt |-> !wb.valid);

endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire loadT load,
	output logic [dataWidth-1:0] pc,
	output logic hlt,
	output writeT regWrite  // writeback port
);

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	writeT memFwd;
	flagsT flags;
	ctrlT exCtrl;
	logic [regAddrWidth-1:0] exRdId;
	logic stall;
	logic branchTaken;
	logic haltSeen;
	logic [dataWidth-1:0] branchTarget;

	fetchStage i_fetch (
		.clk, .rstN, .load,
		.stall, .branchTaken, .branchTarget, .haltSeen,
		.ifId, .pc
	);

	decodeStage i_decode (
		.clk, .rstN, .ifId,
		.flags, .exCtrl, .exRdId,
		.wb(regWrite),  // register file write port
		.idEx, .stall, .branchTaken, .branchTarget, .haltSeen
	);

	executeStage i_execute (
		.clk, .rstN, .idEx,
		.memFwd,
		.wbFwd(regWrite),
		.exMem, .flags, .exCtrl, .exRdId
	);

	resultStage i_result (
		.clk, .rstN, .exMem,
		.memFwd,
		.wb(regWrite),
		.hlt
	);

endmodule

`default_nettype wire

//--- verification/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int hltIdx = 200;     // word index of the closing HLT
	localparam int haltWait = 3000;  // cycles allowed until hlt

	logic clk;
	logic rstN;
	loadT load;
	logic [dataWidth-1:0] pc;
	logic hlt;
	writeT regWrite;

	logic [dataWidth-1:0] prog [2**imemAddrWidth];
	int progLen;
	logic [regAddrWidth-1:0] expRd [512];  // expected write sequence
	logic [dataWidth-1:0] expData [512];
	int expCount;
	logic [dataWidth-1:0] haltAddr;
	int gotCount;
	int mismatchCount;
	int failCount;
	int cycles;
	int quietStart;

	tbClock i_tbClock (.clk);

	cpu i_cpu (
		.clk, .rstN, .load,
		.pc, .hlt, .regWrite
	);

	function automatic logic [15:0] regWord(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] byteWord(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] branchWord(input logic [2:0] cond, input logic [8:0] off);
		return {opB, cond, off};
	endfunction

	function automatic logic [3:0] destReg();
		return 4'(1 + $urandom % 14);  // r15 is the fixed base pointer
	endfunction

	function automatic logic [3:0] srcReg();
		return 4'($urandom % 16);
	endfunction

	function automatic logic [3:0] pickAluOp();
		case ($urandom % 3)
			0: return opAdd;
			1: return opSub;
			default: return opXor;
		endcase
	endfunction

	function automatic logic [3:0] pickShiftOp();
		case ($urandom % 3)
			0: return opSll;
			1: return opSra;
			default: return opRor;
		endcase
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[progLen] = w;
		progLen++;
	endtask

	// prologue fills registers and every reachable data word, then random body
	task automatic genProgram();
		logic [3:0] rd;
		int off;
		emit(byteWord(opLlb, 4'd15, 8'h40));  // base 0x0040
		for (int k = 1; k < 15; k++) begin
			emit(byteWord(opLlb, 4'(k), 8'($urandom)));
			emit(byteWord(opLhb, 4'(k), 8'($urandom)));  // right behind its LLB
		end
		for (int k = 0; k < 16; k++)
			emit(regWord(opSw, 4'(1 + k % 14), 4'd15, 4'(k)));
		while (progLen < hltIdx - 1) begin
			case ($urandom % 10)
				0, 1: emit(regWord(pickAluOp(), destReg(), srcReg(), srcReg()));
				2: emit(regWord(pickShiftOp(), destReg(), srcReg(), 4'($urandom % 16)));
				3: begin
					rd = destReg();
					emit(regWord(opLw, rd, 4'd15, 4'($urandom % 16)));
					if ($urandom % 2 == 0)
						emit(regWord(opAdd, destReg(), rd, srcReg()));  // load-use
				end
				4: emit(regWord(opSw, srcReg(), 4'd15, 4'($urandom % 16)));
				5: emit(byteWord(($urandom % 2 == 0) ? opLlb : opLhb, destReg(), 8'($urandom)));
				6: emit(regWord(opPcs, destReg(), 4'd0, 4'd0));
				default: begin
					emit(regWord(pickAluOp(), destReg(), srcReg(), srcReg()));  // flag setter
					off = $urandom % 4;
					if (progLen + 1 + off > hltIdx)
						off = hltIdx - progLen - 1;  // forward, never past HLT
					emit(branchWord(3'($urandom % 8), 9'(off)));
				end
			endcase
		end
		while (progLen < hltIdx)
			emit(regWord(opPcs, 4'd14, 4'd0, 4'd0));
		emit(regWord(opHlt, 4'd0, 4'd0, 4'd0));
	endtask

	// ISA model, fills expRd/expData and returns the HLT address
	function automatic logic [15:0] runModel();
		logic [15:0] r [16];
		logic [15:0] dm [256];
		logic [15:0] mpc;
		logic [15:0] ins;
		logic [15:0] a, b, res, addr;
		logic [3:0] op, rd;
		logic zf, vf, nf;
		logic wr, taken;
		int sum;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		for (int i = 0; i < 256; i++)
			dm[i] = '0;
		mpc = '0;
		zf = 1'b0;
		vf = 1'b0;
		nf = 1'b0;
		expCount = 0;
		for (int steps = 0; steps < 4096; steps++) begin
			ins = prog[mpc[8:1]];
			op = ins[15:12];
			rd = ins[11:8];
			a = r[ins[7:4]];
			b = r[ins[3:0]];
			addr = a + ({{12{ins[3]}}, ins[3:0]} << 1);  // base + 2*offset
			wr = 1'b0;
			res = '0;
			taken = 1'b0;
			if (op == opHlt)
				return mpc;
			case (op)
				opAdd, opSub: begin
					if (op == opAdd)
						sum = int'($signed(a)) + int'($signed(b));
					else
						sum = int'($signed(a)) - int'($signed(b));
					vf = sum > 32767 || sum < -32768;
					if (sum > 32767)
						res = 16'h7fff;  // clamp high
					else if (sum < -32768)
						res = 16'h8000;
					else
						res = sum[15:0];
					zf = res == '0;
					nf = res[15];
					wr = 1'b1;
				end
				opXor, opSll, opSra, opRor: begin
					case (op)
						opXor: res = a ^ b;
						opSll: res = a << ins[3:0];
						opSra: res = $signed(a) >>> ins[3:0];
						default: res = (a >> ins[3:0]) | (a << (16 - ins[3:0]));
					endcase
					zf = res == '0;  // z only
					wr = 1'b1;
				end
				opLw: begin
					res = dm[addr[8:1]];
					wr = 1'b1;
				end
				opSw: dm[addr[8:1]] = r[rd];
				opLlb: begin
					res = {r[rd][15:8], ins[7:0]};
					wr = 1'b1;
				end
				opLhb: begin
					res = {ins[7:0], r[rd][7:0]};
					wr = 1'b1;
				end
				opPcs: begin
					res = mpc + 16'd2;
					wr = 1'b1;
				end
				opB: begin
					case (ins[11:9])
						condNeq: taken = !zf;
						condEq: taken = zf;
						condGt: taken = !zf && !nf;
						condLt: taken = nf;
						condGte: taken = zf || !nf;
						condLte: taken = zf || nf;
						condOvfl: taken = vf;
						default: taken = 1'b1;
					endcase
				end
				default: ;
			endcase
			if (wr && rd != '0) begin
				r[rd] = res;
				expRd[expCount] = rd;
				expData[expCount] = res;
				expCount++;
			end
			if (taken)
				mpc = mpc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
			else
				mpc = mpc + 16'd2;
		end
		return 16'hffff;  // no HLT reached
	endfunction

	// values read at posedge are the ones held through the cycle just ended
	always @(posedge clk) begin
		if (regWrite.valid) begin
			writeInReset: assert (rstN) else begin
				failCount++;
				$display("register write seen while the core was in reset at %0t", $time);
			end
			writeExpected: assert (gotCount < expCount) else begin
				failCount++;
				$display("unexpected extra register write at %0t", $time);
			end
			if (rstN && gotCount < expCount) begin
				writeValue: assert (regWrite.rdId == expRd[gotCount] &&
					regWrite.data == expData[gotCount]) else begin
					mismatchCount++;
					$display("MISMATCH at %0t: write %0d got r%0d=%h, expected r%0d=%h",
						$time, gotCount, regWrite.rdId, regWrite.data,
						expRd[gotCount], expData[gotCount]);
				end
			end
			gotCount++;
		end
	end

	initial begin
		void'($urandom(16803));
		rstN = 1'b0;
		load = '0;
		gotCount = 0;
		mismatchCount = 0;
		failCount = 0;
		progLen = 0;
		genProgram();
		haltAddr = runModel();
		for (int i = 0; i < progLen; i++) begin
			@(negedge clk);
			load.we = 1'b1;
			load.addr = imemAddrWidth'(i);
			load.data = prog[i];
		end
		@(negedge clk);
		load = '0;
		repeat (8) @(negedge clk);  // reset held past the last loader write
		resetState: assert (!hlt && pc == '0) else begin
			mismatchCount++;
			$display("MISMATCH at %0t: after reset hlt=%b pc=%h", $time, hlt, pc);
		end
		rstN = 1'b1;

		cycles = 0;
		while (!hlt && cycles < haltWait) begin
			@(negedge clk);
			cycles++;
		end
		if (!hlt) begin
			failCount++;
			$display("timeout, hlt did not rise within %0d cycles", haltWait);
		end else begin
			haltPc: assert (pc == haltAddr) else begin
				mismatchCount++;
				$display("MISMATCH at %0t: pc %h at halt, expected %h", $time, pc, haltAddr);
			end
			quietStart = gotCount;
			for (int i = 0; i < 20; i++) begin
				@(negedge clk);
				hltSticky: assert (hlt && pc == haltAddr) else begin
					failCount++;
					$display("core left the halted state at %0t", $time);
				end
			end
			quietAfter: assert (gotCount == quietStart) else begin
				failCount++;
				$display("register writes appeared after halt");
			end
			writeCount: assert (gotCount == expCount) else begin
				mismatchCount++;
				$display("MISMATCH at %0t: %0d writes, expected %0d", $time, gotCount, expCount);
			end
		end

		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/cpu.sv
verification/tbClock.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP = cpuTb
FILELIST = all.f
BUILD_DIR = obj_dir
PASS_MSG = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
